//--- hw/rv32i_types_pkg.sv
package rv32i_types_pkg;

    // Base integer width of RV32I
    localparam int XLEN = 32;

    // Field widths inside a 32-bit instruction
    localparam int OPCODE_W   = 7;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    // Every instruction is one word, no compressed extension
    localparam int INST_BYTES = 4;

    // Raw instruction or data word
    typedef logic [XLEN-1:0] word_t;

    // Byte address of an instruction
    typedef logic [XLEN-1:0] pc_t;

    // Architectural register index, x0 to x31
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Minor opcode fields
    typedef logic [FUNCT3_W-1:0] funct3_t;
    typedef logic [FUNCT7_W-1:0] funct7_t;

    // Major opcodes, encoded with their real bits [6:0]
    // The all-zero encoding is not used by RV32I and marks an unknown opcode
    typedef enum logic [OPCODE_W-1:0] {
        // U-type
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111,
        // J-type
        op_jal     = 7'b1101111,
        // I-type jump
        op_jalr    = 7'b1100111,
        // B-type
        op_branch  = 7'b1100011,
        // I-type load
        op_load    = 7'b0000011,
        // S-type
        op_store   = 7'b0100011,
        // I-type arithmetic
        op_imm     = 7'b0010011,
        // R-type arithmetic
        op_reg     = 7'b0110011,
        // ecall, ebreak and csr access
        op_system  = 7'b1110011,
        // Anything else
        op_illegal = 7'b0000000
    } opcode_e;

endpackage

//--- hw/frontend_pkg.sv
package frontend_pkg;

    // First address fetched after reset
    localparam rv32i_types_pkg::pc_t RESET_PC = 32'h0000_0000;

    // Instruction queue geometry
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = 3;
    localparam int QUEUE_CNT_W = 4;

    // Entries reserved for words still outside the queue
    // One word in memory and one word in decode
    localparam int QUEUE_SLACK = 2;

    // Queue pointer wraps by itself since depth is a power of two
    typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;

    // Count needs one more bit to tell full from empty
    typedef logic [QUEUE_CNT_W-1:0] queue_cnt_t;

    // Running program order of issued instructions
    typedef logic [63:0] order_t;

    // Word returned by instruction memory, with its address
    typedef struct packed {
        rv32i_types_pkg::pc_t   pc;
        rv32i_types_pkg::word_t inst;
    } fetch_packet_t;

    // One decoded instruction
    typedef struct packed {
        rv32i_types_pkg::pc_t       pc;
        rv32i_types_pkg::word_t     inst;
        rv32i_types_pkg::opcode_e   opcode;
        rv32i_types_pkg::reg_addr_t rd;
        rv32i_types_pkg::reg_addr_t rs1;
        rv32i_types_pkg::reg_addr_t rs2;
        rv32i_types_pkg::funct3_t   funct3;
        rv32i_types_pkg::funct7_t   funct7;
        // Sign-extended immediate, zero for R-type and system
        rv32i_types_pkg::word_t     imm;
        logic                       illegal;
    } decoded_inst_t;

    // Record handed to the back end
    typedef struct packed {
        decoded_inst_t dec;
        order_t        order;
    } issue_packet_t;

endpackage

//--- hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        queue_full,
    input  rv32i_types_pkg::word_t      imem_rdata,
    input  logic                        imem_resp,
    output rv32i_types_pkg::pc_t        imem_addr,
    output logic [3:0]                  imem_rmask,
    output logic                        fetch_valid,
    output frontend_pkg::fetch_packet_t fetch_packet
);

    // Address of the word being fetched or about to be fetched
    rv32i_types_pkg::pc_t pc;

    // High while a read is outstanding at the memory
    logic pending;

    // Response that closes the outstanding read
    logic resp_hit;

    assign resp_hit = pending && imem_resp;

    // Request control
    // Only one read in flight; a new one waits for an idle cycle
    // and for room in the queue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= frontend_pkg::RESET_PC;
            pending <= 1'b0;
        end else begin
            if (resp_hit) begin
                pending <= 1'b0;
                // No branches yet, always the next sequential word
                pc      <= pc + rv32i_types_pkg::pc_t'(rv32i_types_pkg::INST_BYTES);
            end else if (!pending && !queue_full) begin
                pending <= 1'b1;
            end
        end
    end

    // Memory port
    // Address stays on pc for the whole request
    assign imem_addr  = pc;
    // Full word read while pending
    assign imem_rmask = pending ? 4'b1111 : 4'b0000;

    // Hand the word to decode in the same cycle it returns
    assign fetch_valid       = resp_hit;
    assign fetch_packet.pc   = pc;
    assign fetch_packet.inst = imem_rdata;

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_valid,
    input  frontend_pkg::fetch_packet_t fetch_packet,
    output logic                        dec_valid,
    output frontend_pkg::decoded_inst_t dec_inst
);

    // Combinational decode result, captured on fetch_valid
    frontend_pkg::decoded_inst_t dec_next;

    // Word under decode
    rv32i_types_pkg::word_t w;

    // Immediates of every format, one of them is picked by opcode
    rv32i_types_pkg::word_t imm_i;
    rv32i_types_pkg::word_t imm_s;
    rv32i_types_pkg::word_t imm_b;
    rv32i_types_pkg::word_t imm_u;
    rv32i_types_pkg::word_t imm_j;

    assign w = fetch_packet.inst;

    // Format immediates, all sign-extended from bit 31
    assign imm_i = {{20{w[31]}}, w[31:20]};
    assign imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    assign imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u = {w[31:12], 12'b0};
    assign imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

    always_comb begin
        dec_next.pc     = fetch_packet.pc;
        dec_next.inst   = w;
        // Register and function fields sit at fixed positions in every format
        dec_next.rd     = w[11:7];
        dec_next.rs1    = w[19:15];
        dec_next.rs2    = w[24:20];
        dec_next.funct3 = w[14:12];
        dec_next.funct7 = w[31:25];

        // Defaults for an unknown opcode
        dec_next.opcode  = rv32i_types_pkg::op_illegal;
        dec_next.imm     = '0;
        dec_next.illegal = 1'b1;

        case (w[6:0])
            rv32i_types_pkg::op_lui,
            rv32i_types_pkg::op_auipc: begin
                dec_next.opcode  = rv32i_types_pkg::opcode_e'(w[6:0]);
                dec_next.imm     = imm_u;
                dec_next.illegal = 1'b0;
            end
            rv32i_types_pkg::op_jal: begin
                dec_next.opcode  = rv32i_types_pkg::op_jal;
                dec_next.imm     = imm_j;
                dec_next.illegal = 1'b0;
            end
            rv32i_types_pkg::op_jalr,
            rv32i_types_pkg::op_load,
            rv32i_types_pkg::op_imm: begin
                dec_next.opcode  = rv32i_types_pkg::opcode_e'(w[6:0]);
                dec_next.imm     = imm_i;
                dec_next.illegal = 1'b0;
            end
            rv32i_types_pkg::op_branch: begin
                dec_next.opcode  = rv32i_types_pkg::op_branch;
                dec_next.imm     = imm_b;
                dec_next.illegal = 1'b0;
            end
            rv32i_types_pkg::op_store: begin
                dec_next.opcode  = rv32i_types_pkg::op_store;
                dec_next.imm     = imm_s;
                dec_next.illegal = 1'b0;
            end
            // R-type and system carry no immediate
            rv32i_types_pkg::op_reg,
            rv32i_types_pkg::op_system: begin
                dec_next.opcode  = rv32i_types_pkg::opcode_e'(w[6:0]);
                dec_next.illegal = 1'b0;
            end
            default: begin
                // Keep the illegal defaults
            end
        endcase
    end

    // Strobe follows fetch_valid by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid;
        end
    end

    // Record only changes when a new word arrives
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            dec_inst <= dec_next;
        end
    end

endmodule

//--- hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  frontend_pkg::decoded_inst_t push_inst,
    input  logic                        pop,
    output frontend_pkg::decoded_inst_t queue_head,
    output logic                        queue_empty,
    output logic                        queue_full
);

    // Entry storage
    frontend_pkg::decoded_inst_t mem [frontend_pkg::QUEUE_DEPTH];

    // Oldest entry at head_ptr and next free slot at tail_ptr
    frontend_pkg::queue_ptr_t head_ptr;
    frontend_pkg::queue_ptr_t tail_ptr;

    // Number of valid entries from 0 to QUEUE_DEPTH
    frontend_pkg::queue_cnt_t count;

    // Qualified requests
    logic do_push;
    logic do_pop;

    // Every slot taken
    logic all_taken;

    assign all_taken = (count == frontend_pkg::queue_cnt_t'(frontend_pkg::QUEUE_DEPTH));

    assign do_pop  = pop && !queue_empty;
    // A full queue still takes a push when the head leaves in the same cycle
    assign do_push = push && (!all_taken || do_pop);

    // Write port
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail_ptr] <= push_inst;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            // Pointer arithmetic wraps at QUEUE_DEPTH
            if (do_push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (do_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is always visible and only meaningful while not empty
    assign queue_head  = mem[head_ptr];
    assign queue_empty = (count == '0);

    // Early full leaves room for the words still in memory and decode
    assign queue_full = (int'(count) + frontend_pkg::QUEUE_SLACK) >= frontend_pkg::QUEUE_DEPTH;

endmodule

//--- hw/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  frontend_pkg::decoded_inst_t queue_head,
    input  logic                        queue_empty,
    output logic                        pop,
    input  logic                        issue_ready,
    output logic                        issue_valid,
    output frontend_pkg::issue_packet_t issue_packet
);

    // Order number for the next record loaded
    frontend_pkg::order_t next_order;

    // Output register frees up when empty or handed over this cycle
    logic out_free;

    assign out_free = !issue_valid || issue_ready;

    // Take the head whenever there is one and a place to put it
    assign pop = !queue_empty && out_free;

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            next_order  <= '0;
        end else begin
            if (pop) begin
                issue_valid <= 1'b1;
                // One step per popped record, so no gaps in order
                next_order  <= next_order + 64'd1;
            end else if (issue_ready) begin
                // Consumed and nothing to replace it
                issue_valid <= 1'b0;
            end
        end
    end

    // Payload holds while the downstream side stalls
    always_ff @(posedge clk) begin
        if (pop) begin
            issue_packet.dec   <= queue_head;
            issue_packet.order <= next_order;
        end
    end

endmodule

//--- hw/cpu_frontend.sv
`timescale 1ns/1ps

module cpu_frontend (
    input  logic                        clk,
    input  logic                        rst_n,
    output rv32i_types_pkg::pc_t        imem_addr,
    output logic [3:0]                  imem_rmask,
    input  rv32i_types_pkg::word_t      imem_rdata,
    input  logic                        imem_resp,
    input  logic                        issue_ready,
    output logic                        issue_valid,
    output frontend_pkg::issue_packet_t issue_packet
);

    // Fetch to decode
    logic                        fetch_valid;
    frontend_pkg::fetch_packet_t fetch_packet;

    // Decode to queue
    logic                        dec_valid;
    frontend_pkg::decoded_inst_t dec_inst;

    // Queue status and head
    logic                        queue_full;
    logic                        queue_empty;
    frontend_pkg::decoded_inst_t queue_head;

    // Dispatch pop strobe
    logic                        pop;

    // Producer, throttled by the queue's early full level
    fetch_stage fetch_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .queue_full   (queue_full),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .imem_addr    (imem_addr),
        .imem_rmask   (imem_rmask),
        .fetch_valid  (fetch_valid),
        .fetch_packet (fetch_packet)
    );

    decode_stage decode_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_packet (fetch_packet),
        .dec_valid    (dec_valid),
        .dec_inst     (dec_inst)
    );

    // Every decoded record is pushed, the slack guarantees room
    inst_queue inst_queue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (dec_valid),
        .push_inst   (dec_inst),
        .pop         (pop),
        .queue_head  (queue_head),
        .queue_empty (queue_empty),
        .queue_full  (queue_full)
    );

    // Consumer, drives the issue port
    dispatch_stage dispatch_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .queue_head   (queue_head),
        .queue_empty  (queue_empty),
        .pop          (pop),
        .issue_ready  (issue_ready),
        .issue_valid  (issue_valid),
        .issue_packet (issue_packet)
    );

endmodule

//--- testbench/cpu_frontend_checker.sv
`timescale 1ns/1ps

module cpu_frontend_checker (
    input logic                        clk,
    input logic                        rst_n,
    input rv32i_types_pkg::pc_t        imem_addr,
    input logic [3:0]                  imem_rmask,
    input logic                        issue_ready,
    input logic                        issue_valid,
    input frontend_pkg::issue_packet_t issue_packet,
    input logic                        dec_valid,
    input frontend_pkg::decoded_inst_t dec_inst,
    input logic                        pop,
    input frontend_pkg::queue_cnt_t    queue_count
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Queue occupancy rebuilt from the push and pop strobes
    int occupancy;

    task automatic record_violation(input string what);
        $error("%s", what);
        fail_count++;
    endtask

    // The ten RV32I major opcodes
    function automatic logic known_opcode(input logic [6:0] op);
        return op inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h63,
                          7'h03, 7'h23, 7'h13, 7'h33, 7'h73};
    endfunction

    // Immediate picked by instruction format and zero for R-type and system
    function automatic rv32i_types_pkg::word_t expected_imm(input rv32i_types_pkg::word_t w);
        case (w[6:0])
            7'h37, 7'h17: return {w[31:12], 12'h000};
            7'h6f:        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            7'h63:        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            7'h23:        return {{21{w[31]}}, w[30:25], w[11:7]};
            7'h67, 7'h03, 7'h13: return {{21{w[31]}}, w[30:20]};
            default:      return '0;
        endcase
    endfunction

    // Fields, immediate, opcode and illegal flag recomputed from the raw word
    function automatic logic decode_matches(input frontend_pkg::decoded_inst_t d);
        logic known;
        known = known_opcode(d.inst[6:0]);
        return d.rd == d.inst[11:7]
            && d.rs1 == d.inst[19:15]
            && d.rs2 == d.inst[24:20]
            && d.funct3 == d.inst[14:12]
            && d.funct7 == d.inst[31:25]
            && d.imm == expected_imm(d.inst)
            && d.illegal == !known
            && d.opcode == (known ? d.inst[6:0] : 7'h00);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(dec_valid) - int'(pop);
        end
    end

    // Outputs settle to reset values one edge into reset
    a_reset_state: assert property (@(posedge clk)
        !rst_n |=> imem_rmask == 4'h0 && !issue_valid && imem_addr == frontend_pkg::RESET_PC)
        else record_violation("outputs not in reset state");

    // Record leaving decode
    a_decode: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> decode_matches(dec_inst))
        else record_violation("decoded record does not match its raw word");

    // Record on the issue port after the queue
    a_issue_decode: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> decode_matches(issue_packet.dec))
        else record_violation("issued record does not match its raw word");

    // Stalled output holds
    a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_packet))
        else record_violation("issue packet changed while stalled");

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> queue_count != frontend_pkg::QUEUE_DEPTH)
        else record_violation("push into a queue with every slot taken");

    // Pop only while pushed records remain
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> occupancy > 0)
        else record_violation("pop from an empty queue");

    // Early full and an idle port keep fetch idle
    a_fetch_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(queue_count) + frontend_pkg::QUEUE_SLACK >= frontend_pkg::QUEUE_DEPTH)
            && imem_rmask == 4'h0 |=> imem_rmask == 4'h0)
        else record_violation("fetch requested while the queue was full");

endmodule

bind cpu_frontend cpu_frontend_checker checker_i (
    .*,
    .queue_count (inst_queue_i.count)
);

//--- testbench/cpu_frontend_tb.sv
`timescale 1ns/1ps

module cpu_frontend_tb;

    // issue_ready patterns
    localparam int READY_LOW    = 0;
    localparam int READY_HIGH   = 1;
    localparam int READY_RANDOM = 2;

    // lui, auipc, jal, jalr, beq, lw, sw, addi,
    // add, ecall, illegal, sub, ebreak, slli, bne, sb
    localparam rv32i_types_pkg::word_t PROGRAM [16] = '{
        32'h1234_50b7, 32'h0000_1117, 32'h0100_00ef, 32'h0000_8067,
        32'hfe20_8ce3, 32'h0041_2183, 32'h0031_2423, 32'hfff2_0213,
        32'h0041_82b3, 32'h0000_0073, 32'hffff_ffff, 32'h4012_8333,
        32'h0010_0073, 32'h0030_9393, 32'h0000_1263, 32'hfe00_0fa3
    };

    logic                        clk;
    logic                        rst_n;
    rv32i_types_pkg::pc_t        imem_addr;
    logic [3:0]                  imem_rmask;
    rv32i_types_pkg::word_t      imem_rdata;
    logic                        imem_resp;
    logic                        issue_ready;
    logic                        issue_valid;
    frontend_pkg::issue_packet_t issue_packet;

    integer               seed = 32'h3943_99b0;
    int                   ready_mode = READY_LOW;
    logic                 mem_enable = 1'b1;
    logic                 mem_busy = 1'b0;
    int                   resp_count = 0;
    int                   issued_count = 0;
    rv32i_types_pkg::pc_t expected_pc = frontend_pkg::RESET_PC;
    int                   error_count = 0;
    int                   errors_before = 0;
    int                   tests_ok = 0;
    int                   tests_bad = 0;
    int                   cycles;
    int                   quiet;

    cpu_frontend dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_rmask   (imem_rmask),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .issue_ready  (issue_ready),
        .issue_valid  (issue_valid),
        .issue_packet (issue_packet)
    );

    // Table word with the whole address folded into the bits above the opcode
    function automatic rv32i_types_pkg::word_t mem_word(input rv32i_types_pkg::pc_t addr);
        rv32i_types_pkg::word_t base;
        base = PROGRAM[addr[5:2]];
        return {base[31:7] ^ addr[31:7] ^ 25'(addr[6:0]), base[6:0]};
    endfunction

    function automatic int total_errors();
        return error_count + dut_i.checker_i.fail_count;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        error_count++;
    endtask

    task automatic note_problem(input string what);
        $display("ERROR %s", what);
        error_count++;
    endtask

    task automatic close_test(input string name);
        if (total_errors() == errors_before) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, total_errors() - errors_before);
            tests_bad++;
        end
        errors_before = total_errors();
    endtask

    // Sample point past the edge where outputs and counters have settled
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_for_issues(input int target, input int limit);
        int n;
        n = 0;
        while (issued_count < target && n < limit) begin
            step_cycle();
            n++;
        end
        assert (issued_count >= target) else note_problem("timeout waiting for issues");
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Coin drawn on the edge and applied 1 ns later
    initial begin : ready_driver
        integer coin;
        issue_ready = 1'b0;
        forever begin
            @(posedge clk);
            coin = $random(seed);
            #1;
            case (ready_mode)
                READY_HIGH:   issue_ready = 1'b1;
                READY_RANDOM: issue_ready = coin[0];
                default:      issue_ready = 1'b0;
            endcase
        end
    end

    // Instruction memory answering after 1 to 4 cycles
    initial begin : memory_model
        int latency;
        imem_resp  = 1'b0;
        imem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_enable && rst_n && imem_rmask == 4'hf) begin
                mem_busy = 1'b1;
                latency  = 1 + ($unsigned($random(seed)) % 4);
                repeat (latency - 1) begin
                    @(posedge clk);
                    #1;
                end
                imem_rdata = mem_word(imem_addr);
                imem_resp  = 1'b1;
                @(posedge clk);
                #1;
                imem_resp  = 1'b0;
                resp_count++;
                mem_busy   = 1'b0;
            end
        end
    end

    // Record taken on the coming edge
    always @(negedge clk) begin
        if (rst_n && issue_valid && issue_ready) begin
            assert (issue_packet.order == 64'(issued_count))
                else report_mismatch("issue_packet.order", issue_packet.order, 64'(issued_count));
            assert (issue_packet.dec.pc == expected_pc)
                else report_mismatch("issue_packet.dec.pc", issue_packet.dec.pc, expected_pc);
            assert (issue_packet.dec.inst == mem_word(issue_packet.dec.pc))
                else report_mismatch("issue_packet.dec.inst", issue_packet.dec.inst,
                                     mem_word(issue_packet.dec.pc));
            issued_count++;
            expected_pc = expected_pc + 32'd4;
        end
    end

    initial begin : main_sequence
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        assert (imem_rmask == 4'h0 && !issue_valid && imem_addr == frontend_pkg::RESET_PC)
            else note_problem("outputs not at reset values");
        rst_n = 1'b1;
        close_test("reset state");

        ready_mode = READY_HIGH;
        wait_for_issues(24, 400);
        close_test("program order");

        ready_mode = READY_RANDOM;
        wait_for_issues(issued_count + 24, 800);
        close_test("random ready");

        // Fetch must go quiet once the queue fills under a long stall
        ready_mode = READY_LOW;
        cycles = 0;
        quiet = 0;
        while (quiet < 16 && cycles < 200) begin
            step_cycle();
            cycles++;
            quiet = (imem_rmask == 4'h0) ? quiet + 1 : 0;
        end
        assert (quiet >= 16) else note_problem("fetch kept requesting under back-pressure");
        close_test("back-pressure");

        // Everything fetched must come out once memory stops answering
        mem_enable = 1'b0;
        ready_mode = READY_HIGH;
        cycles = 0;
        while ((mem_busy || issued_count < resp_count || issue_valid) && cycles < 400) begin
            step_cycle();
            cycles++;
        end
        assert (!mem_busy && !issue_valid) else note_problem("drain did not finish in time");
        assert (issued_count == resp_count)
            else report_mismatch("issued count", issued_count, resp_count);
        close_test("drain");

        $display("summary: %0d ok, %0d failing", tests_ok, tests_bad);
        if (tests_bad == 0 && total_errors() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- cpu_frontend.f
hw/rv32i_types_pkg.sv
hw/frontend_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/inst_queue.sv
hw/dispatch_stage.sv
hw/cpu_frontend.sv
testbench/cpu_frontend_checker.sv
testbench/cpu_frontend_tb.sv
